//--- design/armCtrlPkg.sv
package armCtrlPkg;

  // ============================================================
  // Widths
  // ============================================================
  localparam int instrW   = 32;
  localparam int nzcvW    = 4;
  localparam int aluCtrlW = 4;
  localparam int maskW    = 4;             // One enable per byte lane

  // NZCV bit positions
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Data-processing opcodes, instruction bits 24:21
  localparam logic [aluCtrlW-1:0] aluSub = 4'b0010;
  localparam logic [aluCtrlW-1:0] aluRsb = 4'b0011;
  localparam logic [aluCtrlW-1:0] aluAdd = 4'b0100;
  localparam logic [aluCtrlW-1:0] aluAdc = 4'b0101;
  localparam logic [aluCtrlW-1:0] aluSbc = 4'b0110;
  localparam logic [aluCtrlW-1:0] aluRsc = 4'b0111;
  localparam logic [aluCtrlW-1:0] aluTst = 4'b1000; // Flag-only group starts here
  localparam logic [aluCtrlW-1:0] aluTeq = 4'b1001;
  localparam logic [aluCtrlW-1:0] aluCmp = 4'b1010;
  localparam logic [aluCtrlW-1:0] aluCmn = 4'b1011;

  // Condition field, bits 31:28
  localparam logic [3:0] condEq = 4'h0;
  localparam logic [3:0] condNe = 4'h1;
  localparam logic [3:0] condCs = 4'h2;
  localparam logic [3:0] condCc = 4'h3;
  localparam logic [3:0] condMi = 4'h4;
  localparam logic [3:0] condPl = 4'h5;
  localparam logic [3:0] condVs = 4'h6;
  localparam logic [3:0] condVc = 4'h7;
  localparam logic [3:0] condHi = 4'h8;
  localparam logic [3:0] condLs = 4'h9;
  localparam logic [3:0] condGe = 4'hA;
  localparam logic [3:0] condLt = 4'hB;
  localparam logic [3:0] condGt = 4'hC;
  localparam logic [3:0] condLe = 4'hD;
  localparam logic [3:0] condAl = 4'hE;

  // Instruction class, bits 27:26
  localparam logic [1:0] classDp     = 2'b00;
  localparam logic [1:0] classMem    = 2'b01;
  localparam logic [1:0] classBranch = 2'b10;
  localparam logic [1:0] classOther  = 2'b11; // Coprocessor and SWI space

  localparam logic [3:0] regPc = 4'd15;

  // One instruction word, two decodes over the same bits
  typedef union packed {
    struct packed {
      logic [3:0]          cond;
      logic [1:0]          cls;
      logic                imm;             // Operand 2 is an immediate
      logic [aluCtrlW-1:0] opcode;
      logic                s;               // Set flags
      logic [3:0]          rn;
      logic [3:0]          rd;
      logic [11:0]         op2;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  cls;
      logic        imm;                     // Set means register offset here
      logic        p;
      logic        u;                       // Up, add the offset
      logic        b;                       // Byte access
      logic        w;
      logic        l;                       // Load
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } ls;
  } instrWordT;

endpackage

//--- design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  armCtrlPkg::instrWordT          InstrD,
  output logic [1:0]                     RegSrcD,
  output logic [1:0]                     ImmSrcD,
  output logic                           ALUSrcD,
  output logic                           MemtoRegD,
  output logic                           RegWriteD,
  output logic                           MemWriteD,
  output logic                           BranchD,
  output logic                           PCSrcD,
  output logic                           ByteD,
  output logic                           FlagWriteD,
  output logic [armCtrlPkg::aluCtrlW-1:0] ALUControlD
);

  import armCtrlPkg::*;

  logic flagOnly;                           // TST, TEQ, CMP, CMN
  logic extSpace;                           // Multiply and halfword encodings
  logic badMemOp;                           // Register offset with bit 4 set

  assign flagOnly = InstrD.dp.opcode inside {aluTst, aluTeq, aluCmp, aluCmn};
  assign extSpace = !InstrD.dp.imm && InstrD.dp.op2[7] && InstrD.dp.op2[4];
  assign badMemOp = InstrD.ls.imm && InstrD.ls.offset[4];

  // ============================================================
  // Main decode
  // ============================================================
  always_comb begin
    RegSrcD     = 2'b00;                    // Anything unhandled is a no-op
    ImmSrcD     = 2'b00;
    ALUSrcD     = 1'b0;
    MemtoRegD   = 1'b0;
    RegWriteD   = 1'b0;
    MemWriteD   = 1'b0;
    BranchD     = 1'b0;
    ByteD       = 1'b0;
    FlagWriteD  = 1'b0;
    ALUControlD = aluAdd;
    case (InstrD.dp.cls)
      classDp: begin
        // Flag-only opcodes with S clear are MSR/MRS/BX/CLZ, not handled
        if (!extSpace && !(flagOnly && !InstrD.dp.s)) begin
          ALUSrcD     = InstrD.dp.imm;
          RegWriteD   = !flagOnly;          // Compares only touch NZCV
          FlagWriteD  = InstrD.dp.s;
          ALUControlD = InstrD.dp.opcode;
        end
      end
      classMem: begin
        if (!badMemOp) begin
          RegSrcD     = {!InstrD.ls.l, 1'b0}; // Store reads Rd as write data
          ImmSrcD     = 2'b01;              // 12-bit offset
          ALUSrcD     = !InstrD.ls.imm;     // Inverted sense for LDR/STR
          MemtoRegD   = InstrD.ls.l;
          RegWriteD   = InstrD.ls.l;
          MemWriteD   = !InstrD.ls.l;
          ByteD       = InstrD.ls.b;
          ALUControlD = InstrD.ls.u ? aluAdd : aluSub;
        end
      end
      classBranch: begin
        RegSrcD   = 2'b01;                  // Rn is the PC
        ImmSrcD   = 2'b10;                  // 24-bit word offset
        ALUSrcD   = 1'b1;
        BranchD   = 1'b1;                   // Link bit ignored
      end
      classOther: begin
        // Coprocessor and SWI fall through as no-ops
      end
    endcase
  end

  // Any register write that lands in R15 redirects fetch
  assign PCSrcD = BranchD || (RegWriteD && (InstrD.dp.rd == regPc));

endmodule

//--- design/executeCtrl.sv
`timescale 1ns/1ps

module executeCtrl (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic                            StallE,
  input  logic                            FlushE,
  input  armCtrlPkg::instrWordT           InstrD,
  input  logic                            ALUSrcD,
  input  logic                            MemtoRegD,
  input  logic                            RegWriteD,
  input  logic                            MemWriteD,
  input  logic                            BranchD,
  input  logic                            PCSrcD,
  input  logic                            ByteD,
  input  logic                            FlagWriteD,
  input  logic [armCtrlPkg::aluCtrlW-1:0] ALUControlD,
  input  logic [armCtrlPkg::nzcvW-1:0]    FlagsE,
  input  logic [armCtrlPkg::nzcvW-1:0]    ALUFlagsE,
  input  logic                            ShifterCarryOutE,
  input  logic [1:0]                      AddrLowE,
  output logic                            ALUSrcE,
  output logic [armCtrlPkg::aluCtrlW-1:0] ALUControlE,
  output logic                            BranchTakenE,
  output logic                            BranchE,
  output logic                            PCSrcE,
  output logic                            RegWriteGatedE,
  output logic                            MemWriteGatedE,
  output logic                            MemtoRegE,
  output logic                            PCSrcGatedE,
  output logic [armCtrlPkg::maskW-1:0]    ByteMaskE,
  output logic [armCtrlPkg::nzcvW-1:0]    FlagsNextE,
  output logic                            SetFlagsE
);

  import armCtrlPkg::*;

  logic [3:0] condE;
  logic       regWriteE, memWriteE, byteE, flagWriteE;
  logic       condPass;
  logic       arithE;

  // ============================================================
  // Decode to Execute register
  // ============================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN || FlushE) begin             // Flush beats stall
      condE <= '0;
      {ALUSrcE, MemtoRegE, regWriteE, memWriteE} <= '0;
      {BranchE, PCSrcE, byteE, flagWriteE} <= '0;
      ALUControlE <= '0;
    end else if (!StallE) begin
      condE       <= InstrD.dp.cond;
      ALUSrcE     <= ALUSrcD;
      MemtoRegE   <= MemtoRegD;
      regWriteE   <= RegWriteD;
      memWriteE   <= MemWriteD;
      BranchE     <= BranchD;
      PCSrcE      <= PCSrcD;
      byteE       <= ByteD;
      flagWriteE  <= FlagWriteD;
      ALUControlE <= ALUControlD;
    end
  end

  // Condition check against forwarded NZCV
  always_comb begin
    case (condE)
      condEq:  condPass = FlagsE[flagZ];
      condNe:  condPass = !FlagsE[flagZ];
      condCs:  condPass = FlagsE[flagC];
      condCc:  condPass = !FlagsE[flagC];
      condMi:  condPass = FlagsE[flagN];
      condPl:  condPass = !FlagsE[flagN];
      condVs:  condPass = FlagsE[flagV];
      condVc:  condPass = !FlagsE[flagV];
      condHi:  condPass = FlagsE[flagC] && !FlagsE[flagZ];
      condLs:  condPass = !FlagsE[flagC] || FlagsE[flagZ];
      condGe:  condPass = FlagsE[flagN] == FlagsE[flagV];
      condLt:  condPass = FlagsE[flagN] != FlagsE[flagV];
      condGt:  condPass = !FlagsE[flagZ] && (FlagsE[flagN] == FlagsE[flagV]);
      condLe:  condPass = FlagsE[flagZ] || (FlagsE[flagN] != FlagsE[flagV]);
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;             // NV space never executes
    endcase
  end

  // Gate every side effect with the condition
  assign RegWriteGatedE = regWriteE && condPass;
  assign MemWriteGatedE = memWriteE && condPass;
  assign PCSrcGatedE    = PCSrcE && condPass;
  assign BranchTakenE   = BranchE && condPass;
  assign SetFlagsE      = flagWriteE && condPass;

  // Logical ops take C from the shifter and leave V alone
  assign arithE = ALUControlE inside {aluAdd, aluSub, aluRsb, aluAdc,
                                      aluSbc, aluRsc, aluCmp, aluCmn};
  assign FlagsNextE = arithE ? ALUFlagsE
                             : {ALUFlagsE[flagN], ALUFlagsE[flagZ],
                                ShifterCarryOutE, FlagsE[flagV]};

  // Byte lanes for stores
  always_comb begin
    if (!memWriteE)  ByteMaskE = '0;
    else if (byteE)  ByteMaskE = maskW'(1) << AddrLowE; // One lane
    else             ByteMaskE = '1;        // Full word
  end

  // A branch is never a store, whatever the condition
  branchNotStore: assert property (@(posedge clk) disable iff (!arstN)
    !(BranchTakenE && MemWriteGatedE))
    else $error("branch taken and memory write in the same Execute cycle");

endmodule

//--- design/memWbCtrl.sv
`timescale 1ns/1ps

module memWbCtrl (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         StallM,
  input  logic                         StallW,
  input  logic                         FlushW,
  input  logic                         RegWriteGatedE,
  input  logic                         MemWriteGatedE,
  input  logic                         MemtoRegE,
  input  logic                         PCSrcGatedE,
  input  logic [armCtrlPkg::maskW-1:0] ByteMaskE,
  input  logic [armCtrlPkg::nzcvW-1:0] FlagsNextE,
  input  logic                         SetFlagsE,
  output logic                         MemWriteM,
  output logic [armCtrlPkg::maskW-1:0] ByteMaskM,
  output logic [armCtrlPkg::nzcvW-1:0] FlagsNextM,
  output logic                         SetFlagsM,
  output logic                         PCSrcM,
  output logic                         MemtoRegW,
  output logic                         RegWriteW,
  output logic                         PCSrcW,
  output logic [armCtrlPkg::nzcvW-1:0] FlagsNextW,
  output logic                         SetFlagsW
);

  logic regWriteM, memtoRegM;

  // ============================================================
  // Execute to Memory register with stall only
  // ============================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {MemWriteM, regWriteM, memtoRegM, PCSrcM, SetFlagsM} <= '0;
      ByteMaskM  <= '0;
      FlagsNextM <= '0;
    end else if (!StallM) begin
      MemWriteM  <= MemWriteGatedE;
      regWriteM  <= RegWriteGatedE;
      memtoRegM  <= MemtoRegE;
      PCSrcM     <= PCSrcGatedE;
      ByteMaskM  <= ByteMaskE;
      FlagsNextM <= FlagsNextE;
      SetFlagsM  <= SetFlagsE;
    end
  end

  // Memory to Writeback register where flush wins over stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN || FlushW) begin
      {MemtoRegW, RegWriteW, PCSrcW, SetFlagsW} <= '0;
      FlagsNextW <= '0;
    end else if (!StallW) begin
      MemtoRegW  <= memtoRegM;
      RegWriteW  <= regWriteM;
      PCSrcW     <= PCSrcM;
      FlagsNextW <= FlagsNextM;
      SetFlagsW  <= SetFlagsM;
    end
  end

endmodule

//--- design/flagsReg.sv
`timescale 1ns/1ps

module flagsReg (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         StallW,
  input  logic [armCtrlPkg::nzcvW-1:0] FlagsNextM,
  input  logic                         SetFlagsM,
  input  logic [armCtrlPkg::nzcvW-1:0] FlagsNextW,
  input  logic                         SetFlagsW,
  output logic [armCtrlPkg::nzcvW-1:0] FlagsE
);

  import armCtrlPkg::*;

  logic [nzcvW-1:0] flagsQ;                 // Architectural NZCV

  // ============================================================
  // Commit from Writeback
  // ============================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
    end else if (SetFlagsW && !StallW) begin
      flagsQ <= FlagsNextW;
    end
  end

  // Youngest older setter wins, Memory before Writeback
  assign FlagsE = SetFlagsM ? FlagsNextM
                : SetFlagsW ? FlagsNextW
                : flagsQ;

  flagsKnown: assert property (@(posedge clk) disable iff (!arstN)
    !$isunknown(flagsQ))
    else $error("stored NZCV holds X or Z");

endmodule

//--- design/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic                            clk,
  input  logic                            arstN,
  input  armCtrlPkg::instrWordT           InstrD,
  input  logic [armCtrlPkg::nzcvW-1:0]    ALUFlagsE,
  input  logic                            ShifterCarryOutE,
  input  logic [armCtrlPkg::instrW-1:0]   ALUResultE,
  input  logic                            StallE,
  input  logic                            FlushE,
  input  logic                            StallM,
  input  logic                            StallW,
  input  logic                            FlushW,
  output logic [1:0]                      RegSrcD,
  output logic [1:0]                      ImmSrcD,
  output logic                            PCWrPendingF,
  output logic                            ALUSrcE,
  output logic [armCtrlPkg::aluCtrlW-1:0] ALUControlE,
  output logic                            BranchTakenE,
  output logic [armCtrlPkg::nzcvW-1:0]    FlagsE,
  output logic                            MemWriteM,
  output logic [armCtrlPkg::maskW-1:0]    ByteMaskM,
  output logic                            MemtoRegW,
  output logic                            RegWriteW,
  output logic                            PCSrcW
);

  import armCtrlPkg::*;

  // Decode
  logic ALUSrcD, MemtoRegD, RegWriteD, MemWriteD, BranchD, PCSrcD, ByteD, FlagWriteD;
  logic [aluCtrlW-1:0] ALUControlD;
  // Execute
  logic PCSrcE, RegWriteGatedE, MemWriteGatedE, MemtoRegE, PCSrcGatedE, SetFlagsE;
  logic [maskW-1:0] ByteMaskE;
  logic [nzcvW-1:0] FlagsNextE;
  // Memory and Writeback
  logic PCSrcM, SetFlagsM, SetFlagsW;
  logic [nzcvW-1:0] FlagsNextM, FlagsNextW;

  // ============================================================
  // Stages
  // ============================================================
  instrDecoder u_dec (.*);

  executeCtrl u_exe (
    .*,
    .BranchE  (),                           // Raw branch bit, only used inside
    .AddrLowE (ALUResultE[1:0])             // Byte lane of the address
  );

  memWbCtrl u_memWb (.*);

  flagsReg u_flags (.*);

  // Fetch must hold while any PC write is in flight
  assign PCWrPendingF = PCSrcD || PCSrcE || PCSrcM;

endmodule

//--- dv/ctrlTests.svh
  // Opcode and condition values as the ARM encoding defines them
  localparam logic [3:0]  opAnd  = 4'h0;
  localparam logic [3:0]  opSub  = 4'h2;
  localparam logic [3:0]  opAdd  = 4'h4;
  localparam logic [3:0]  opCmp  = 4'hA;
  localparam logic [3:0]  opMov  = 4'hD;
  localparam logic [3:0]  condEq = 4'h0;
  localparam logic [3:0]  condNe = 4'h1;
  localparam logic [3:0]  condAl = 4'hE;
  localparam logic [31:0] nopInstr = {4'hE, 2'b11, 26'd0}; // Coprocessor space

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Immediate operand with Rn as R1
  function automatic logic [31:0] dpInstr(input logic [3:0] cond, input logic [3:0] op,
                                          input logic s, input logic [3:0] rd);
    return {cond, 2'b00, 1'b1, op, s, 4'd1, rd, 12'h0FF};
  endfunction

  function automatic logic [31:0] memInstr(input logic load, input logic byteB,
                                           input logic up);
    return {condAl, 2'b01, 1'b0, 1'b1, up, byteB, 1'b0, load, 4'd1, 4'd2, 12'h004};
  endfunction

  function automatic logic [31:0] brInstr(input logic [3:0] cond);
    return {cond, 3'b101, 1'b0, 24'h000010}; // No link
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;                                     // Inputs change just after the edge
  endtask

  task automatic checkValue(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp) else begin
      valueErrs++;
      $display("error %s: expected 0x%0h, got 0x%0h", name, exp, act);
    end
  endtask

  task automatic requireTrue(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      otherErrs++;
      $display("%s", what);
    end
  endtask

  // One DP instruction through the pipe with FlagsE checked in M, W and after commit
  task automatic setterPipe(input logic [31:0] instr, input logic [3:0] alu, input logic shc,
                            input logic [3:0] expF, input logic expRegW);
    tick();
    InstrD = instr;
    tick();                                 // In Execute
    InstrD           = nopInstr;
    ALUFlagsE        = alu;
    ShifterCarryOutE = shc;
    for (int i = 1; i <= 3; i++) begin
      tick();
      #1;
      checkValue("FlagsE", expF, FlagsE);
      if (i == 2) checkValue("RegWriteW", expRegW, RegWriteW);
    end
    flagsModel = expF;
  endtask

  task automatic branchPipe(input logic [3:0] cond, input logic taken);
    tick();
    InstrD = brInstr(cond);
    #1;
    checkValue("PCWrPendingF", 1'b1, PCWrPendingF); // Decode
    checkValue("RegSrcD", 2'b01, RegSrcD);        // PC as base register
    checkValue("ImmSrcD", 2'b10, ImmSrcD);
    tick();
    InstrD = nopInstr;
    #1;
    checkValue("BranchTakenE", taken, BranchTakenE);
    checkValue("PCWrPendingF", 1'b1, PCWrPendingF); // Execute sees the raw bit
    tick();
    #1;
    checkValue("PCWrPendingF", taken, PCWrPendingF); // Memory carries the gated bit
    tick();
    #1;
    checkValue("PCSrcW", taken, PCSrcW);
  endtask

  task automatic memPipe(input logic load, input logic byteB, input logic up,
                         input logic [1:0] addr);
    logic [3:0] expMask;
    expMask = load ? 4'h0 : (byteB ? (4'h1 << addr) : 4'hF);
    tick();
    InstrD = memInstr(load, byteB, up);
    #1;
    checkValue("RegSrcD", load ? 2'b00 : 2'b10, RegSrcD); // Store reads Rd
    checkValue("ImmSrcD", 2'b01, ImmSrcD);
    tick();
    InstrD     = nopInstr;
    rngState   = xorshift32(rngState);
    ALUResultE = {rngState[31:2], addr};    // Upper bits are noise
    #1;
    checkValue("ALUControlE", up ? opAdd : opSub, ALUControlE);
    tick();
    #1;
    checkValue("MemWriteM", !load, MemWriteM);
    checkValue("ByteMaskM", expMask, ByteMaskM);
    tick();
    #1;
    checkValue("MemtoRegW", load, MemtoRegW);
    checkValue("RegWriteW", load, RegWriteW);
  endtask

  // SUBS straight into MOVNE with Z forwarded from Memory
  task automatic subsThenMovNe(input logic [3:0] subFlags);
    tick();
    InstrD = dpInstr(condAl, opSub, 1'b1, 4'd4);
    tick();
    InstrD    = dpInstr(condNe, opMov, 1'b0, 4'd5);
    ALUFlagsE = subFlags;
    tick();                                 // MOVNE in Execute
    InstrD = nopInstr;
    #1;
    checkValue("FlagsE", subFlags, FlagsE);
    tick();
    tick();
    #1;
    checkValue("RegWriteW", !subFlags[2], RegWriteW);
    flagsModel = subFlags;
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic flagUpdateTest();
    logic [3:0] alu;
    logic       shc;
    rngState = xorshift32(rngState);
    alu      = rngState[3:0];
    setterPipe(dpInstr(condAl, opAdd, 1'b1, 4'd3), alu, 1'b0, alu, 1'b1);
    rngState = xorshift32(rngState);
    alu      = {rngState[3:1], !flagsModel[0]}; // V must differ to be seen kept
    shc      = !flagsModel[1];
    setterPipe(dpInstr(condAl, opAnd, 1'b1, 4'd3), alu, shc,
               {alu[3:2], shc, flagsModel[0]}, 1'b1);
  endtask

  task automatic condExecTest();
    setterPipe(dpInstr(condAl, opAdd, 1'b1, 4'd3), 4'h0, 1'b0, 4'h0, 1'b1); // Z clear
    setterPipe(dpInstr(condEq, opAdd, 1'b1, 4'd3), 4'hF, 1'b0, 4'h0, 1'b0);
    setterPipe(dpInstr(condAl, opAdd, 1'b1, 4'd3), 4'h4, 1'b0, 4'h4, 1'b1); // Z set
    setterPipe(dpInstr(condEq, opAdd, 1'b1, 4'd3), 4'h8, 1'b0, 4'h8, 1'b1);
    setterPipe(dpInstr(condAl, opCmp, 1'b1, 4'd3), 4'h6, 1'b0, 4'h6, 1'b0); // No Rd write
  endtask

  task automatic branchTest();
    branchPipe(condAl, 1'b1);
    branchPipe(condNe, !flagsModel[2]);     // Z is set here so NE fails
  endtask

  task automatic memAccessTest();
    for (int a = 0; a < 4; a++) begin
      memPipe(1'b0, 1'b1, 1'b1, a[1:0]);    // STRB on every lane
    end
    memPipe(1'b0, 1'b0, 1'b0, 2'd1);        // STR with down offset
    memPipe(1'b1, 1'b0, 1'b1, 2'd3);        // LDR
  endtask

  task automatic stallFlushTest();
    tick();
    InstrD = dpInstr(condAl, opSub, 1'b0, 4'd6);
    tick();                                 // SUB in Execute
    StallE = 1'b1;
    InstrD = memInstr(1'b1, 1'b0, 1'b1);    // Would change ALUControlE if loaded
    repeat (3) begin
      tick();
      #1;
      requireTrue(ALUControlE === opSub && ALUSrcE === 1'b1,
                  "Execute outputs changed while StallE was held");
    end
    tick();
    StallE    = 1'b0;
    FlushE    = 1'b1;                       // ADDS dropped on entry to Execute
    InstrD    = dpInstr(condAl, opAdd, 1'b1, 4'd6);
    ALUFlagsE = ~flagsModel;
    tick();
    FlushE = 1'b0;
    InstrD = nopInstr;
    tick();
    tick();
    #1;
    checkValue("RegWriteW", 1'b0, RegWriteW);
    checkValue("FlagsE", flagsModel, FlagsE);
    tick();
    InstrD = memInstr(1'b1, 1'b0, 1'b1);
    tick();                                 // Load in Execute
    InstrD = nopInstr;
    tick();                                 // Load in Memory
    FlushW = 1'b1;
    tick();
    FlushW = 1'b0;
    #1;
    checkValue("RegWriteW", 1'b0, RegWriteW);
  endtask

  task automatic forwardingTest();
    rngState = xorshift32(rngState);
    subsThenMovNe(rngState[3:0] | 4'b0100); // Z set so MOVNE is skipped
    rngState = xorshift32(rngState);
    subsThenMovNe(rngState[3:0] & 4'b1011);
  endtask

//--- dv/armControllerTb.sv
`timescale 1ns/1ps

module armControllerTb;

  // Six tests take about 90 cycles, the rest is margin
  localparam int maxCycles = 200;

  logic        clk;
  logic        arstN;
  logic [31:0] InstrD;
  logic [3:0]  ALUFlagsE;
  logic        ShifterCarryOutE;
  logic [31:0] ALUResultE;
  logic        StallE;
  logic        FlushE;
  logic        StallM;
  logic        StallW;
  logic        FlushW;
  logic [1:0]  RegSrcD;
  logic [1:0]  ImmSrcD;
  logic        PCWrPendingF;
  logic        ALUSrcE;
  logic [3:0]  ALUControlE;
  logic        BranchTakenE;
  logic [3:0]  FlagsE;
  logic        MemWriteM;
  logic [3:0]  ByteMaskM;
  logic        MemtoRegW;
  logic        RegWriteW;
  logic        PCSrcW;

  int          valueErrs = 0;               // Wrong values seen
  int          otherErrs = 0;               // Any other failed check
  int          cycles    = 0;
  logic [31:0] rngState  = 32'd72868;
  logic [3:0]  flagsModel = 4'h0;           // Expected architectural NZCV

  armController u_dut (.*);

  `include "ctrlTests.svh"

  // ============================================================
  // Clock, timeout and main sequence
  // ============================================================
  initial clk = 1'b0;
  always #20 clk = ~clk;                    // 40 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    arstN            = 1'b0;
    InstrD           = nopInstr;
    ALUFlagsE        = 4'h0;
    ShifterCarryOutE = 1'b0;
    ALUResultE       = 32'h0;
    StallE           = 1'b0;
    FlushE           = 1'b0;
    StallM           = 1'b0;
    StallW           = 1'b0;
    FlushW           = 1'b0;
    repeat (2) @(posedge clk);              // Two cycles in reset
    #2 arstN = 1'b1;

    flagUpdateTest();
    condExecTest();
    branchTest();
    memAccessTest();
    stallFlushTest();
    forwardingTest();

    $display("errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+dv
design/armCtrlPkg.sv
design/instrDecoder.sv
design/executeCtrl.sv
design/memWbCtrl.sv
design/flagsReg.sv
design/armController.sv
dv/armControllerTb.sv

//--- Bender.yml
package:
  name: arm_controller

sources:
  - design/armCtrlPkg.sv
  - design/instrDecoder.sv
  - design/executeCtrl.sv
  - design/memWbCtrl.sv
  - design/flagsReg.sv
  - design/armController.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/armControllerTb.sv
